//--- Bender.yml
package:
  name: systimer

sources:
  - hw/systimer_pkg.sv
  - hw/resetn_synchronizer.sv
  - hw/systimer.sv
  - hw/timer_compare.sv
  - hw/timer_regs.sv
  - hw/timer_subsys_top.sv
  - target: simulation
    files:
      - dv/tb_clkgen.sv
      - dv/tb_timer_subsys.sv

//--- dv/tb_clkgen.sv
`timescale 1ns/10ps

module tb_clkgen (
    output logic clk_sys,
    output logic clk_32k,
    output logic rstn_sys
);

localparam int unsigned sys_half     = 4;    // 8 ns period
localparam int unsigned slow_half    = 120;  // 240 ns, the 32 kHz clock scaled down
localparam int unsigned reset_cycles = 16;

initial begin
    clk_sys = 1'b0;
    forever #(sys_half) clk_sys = ~clk_sys;
end

// slow edges land on falling clk_sys edges, so the two never coincide
initial begin
    clk_32k = 1'b0;
    forever #(slow_half) clk_32k = ~clk_32k;
end

initial begin
    rstn_sys = 1'b0;
    repeat (reset_cycles) @(posedge clk_sys);
    rstn_sys <= 1'b1;
end

endmodule

//--- dv/tb_timer_subsys.sv
`timescale 1ns/10ps

module tb_timer_subsys;

localparam int unsigned test_cycles    = 12000;  // rough length of all tests together
localparam int unsigned timeout_cycles = test_cycles * 5 / 3;
localparam int unsigned irq_wait_limit = 3000;   // 6-bit offset plus margin, in clk_sys cycles
localparam int unsigned counts_div     = 240 / 8;  // clk_sys cycles per slow count

logic                                clk_sys;
logic                                clk_32k;
logic                                rstn_sys;
logic                                req_valid;
logic                                req_ready;
logic                                req_write;
logic [systimer_pkg::addr_width-1:0] req_addr;
logic [systimer_pkg::data_width-1:0] req_wdata;
logic                                rsp_valid;
logic                                rsp_ready;
logic [systimer_pkg::data_width-1:0] rsp_rdata;
logic                                irq;

logic [31:0] lfsr_q = 32'h9250;
int unsigned cycle_cnt = 0;
int unsigned last_accept;

logic [systimer_pkg::time_width-1:0] model_cmp [systimer_pkg::num_cmp];
logic [systimer_pkg::num_cmp-1:0]    model_en;
logic [systimer_pkg::num_cmp-1:0]    model_pend;
logic [systimer_pkg::num_cmp-1:0]    model_fired;  // hit already taken while enabled

tb_clkgen clkgen_i (
    .clk_sys  ( clk_sys  ),
    .clk_32k  ( clk_32k  ),
    .rstn_sys ( rstn_sys )
);

timer_subsys_top dut_i (
    .clk_sys   ( clk_sys   ),
    .clk_32k   ( clk_32k   ),
    .rstn_sys  ( rstn_sys  ),
    .req_valid ( req_valid ),
    .req_ready ( req_ready ),
    .req_write ( req_write ),
    .req_addr  ( req_addr  ),
    .req_wdata ( req_wdata ),
    .rsp_valid ( rsp_valid ),
    .rsp_ready ( rsp_ready ),
    .rsp_rdata ( rsp_rdata ),
    .irq       ( irq       )
);

// galois form of x^32 + x^22 + x^2 + x + 1
function automatic logic [31:0] lfsr_next(input logic [31:0] state);
    if (state[0]) begin
        return (state >> 1) ^ 32'h8020_0003;
    end
    return state >> 1;
endfunction

task automatic draw_bits(input int unsigned n, output logic [31:0] value);
    value = '0;
    for (int i = 0; i < n; i++) begin
        value  = {value[30:0], lfsr_q[0]};
        lfsr_q = lfsr_next(lfsr_q);
    end
endtask

function automatic logic [systimer_pkg::addr_width-1:0] chan_addr(
    input int unsigned ch,
    input logic        hi
);
    return systimer_pkg::addr_width'(systimer_pkg::addr_cmp0_lo + 2 * ch + hi);
endfunction

function automatic logic [systimer_pkg::data_width-1:0] ref_read(
    input logic [systimer_pkg::addr_width-1:0] addr,
    input logic [systimer_pkg::time_width-1:0] now
);
    logic [systimer_pkg::data_width-1:0] data;
    logic [systimer_pkg::num_cmp-1:0]    hit;
    data = '0;
    hit  = '0;
    for (int n = 0; n < systimer_pkg::num_cmp; n++) begin
        if (addr == chan_addr(n, 1'b0)) begin
            data = model_cmp[n][systimer_pkg::data_width-1:0];
        end
        if (addr == chan_addr(n, 1'b1)) begin
            data = model_cmp[n][systimer_pkg::time_width-1:systimer_pkg::data_width];
        end
        hit[n] = model_en[n] & ~model_fired[n] & (now >= model_cmp[n]);  // fires once per arm
    end
    if (addr == systimer_pkg::addr_ctrl) begin
        data[systimer_pkg::num_cmp-1:0] = model_en;
    end
    if (addr == systimer_pkg::addr_status) begin
        data[systimer_pkg::num_cmp-1:0] = model_pend | hit;
    end
    return data;
endfunction

task automatic abort_run();
    $display("Some tests failed");
    $fatal(1);
endtask

task automatic check(
    input string       name,
    input logic [63:0] expected,
    input logic [63:0] actual
);
    if (expected !== actual) begin
        $display("error: %s expected %0h actual %0h", name, expected, actual);
        abort_run();
    end
endtask

task automatic bus_access(
    input  logic                                wr,
    input  logic [systimer_pkg::addr_width-1:0] addr,
    input  logic [systimer_pkg::data_width-1:0] wdata,
    output logic [systimer_pkg::data_width-1:0] rdata
);
    logic [31:0] gap;
    logic [31:0] stall;
    draw_bits(2, gap);
    repeat (gap) @(posedge clk_sys);
    @(posedge clk_sys);
    req_valid <= 1'b1;
    req_write <= wr;
    req_addr  <= addr;
    req_wdata <= wdata;
    do begin
        @(posedge clk_sys);
    end while (!req_ready);
    last_accept = cycle_cnt;
    req_valid <= 1'b0;
    forever begin
        draw_bits(1, stall);
        rsp_ready <= stall[0];  // random back-pressure on the response
        @(posedge clk_sys);
        if (rsp_valid && rsp_ready) begin
            break;
        end
    end
    rdata = rsp_rdata;
    rsp_ready <= 1'b0;
endtask

task automatic reg_write(
    input logic [systimer_pkg::addr_width-1:0] addr,
    input logic [systimer_pkg::data_width-1:0] data
);
    logic [systimer_pkg::data_width-1:0] rsp;
    bus_access(1'b1, addr, data, rsp);
    check("write response data", 0, rsp);
    for (int n = 0; n < systimer_pkg::num_cmp; n++) begin
        if (addr == chan_addr(n, 1'b0)) begin
            model_cmp[n][systimer_pkg::data_width-1:0] = data;
            model_fired[n] = 1'b0;
        end
        if (addr == chan_addr(n, 1'b1)) begin
            model_cmp[n][systimer_pkg::time_width-1:systimer_pkg::data_width] = data;
            model_fired[n] = 1'b0;
        end
    end
    if (addr == systimer_pkg::addr_ctrl) begin
        model_en = data[systimer_pkg::num_cmp-1:0];
    end
    if (addr == systimer_pkg::addr_status) begin
        model_pend = model_pend & ~data[systimer_pkg::num_cmp-1:0];
    end
endtask

task automatic check_reg(
    input string                               name,
    input logic [systimer_pkg::addr_width-1:0] addr,
    input logic [systimer_pkg::time_width-1:0] now
);
    logic [systimer_pkg::data_width-1:0] expected;
    logic [systimer_pkg::data_width-1:0] actual;
    expected = ref_read(addr, now);
    bus_access(1'b0, addr, '0, actual);
    check(name, expected, actual);
    if (addr == systimer_pkg::addr_status) begin
        model_pend  = expected[systimer_pkg::num_cmp-1:0];
        model_fired = model_fired | model_pend;
    end
endtask

// the high word comes from the snapshot taken with the low word
task automatic read_time(output logic [63:0] now, output int unsigned accepted);
    logic [31:0] lo;
    logic [31:0] hi;
    bus_access(1'b0, systimer_pkg::addr_time_lo, '0, lo);
    accepted = last_accept;
    bus_access(1'b0, systimer_pkg::addr_time_hi, '0, hi);
    now = {hi, lo};
endtask

task automatic wait_irq();
    int unsigned waited;
    waited = 0;
    while (!irq) begin
        @(posedge clk_sys);
        waited++;
        if (waited > irq_wait_limit) begin
            $display("irq did not rise within %0d cycles of arming a compare", irq_wait_limit);
            abort_run();
        end
    end
endtask

always @(posedge clk_sys) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= timeout_cycles) begin
        $display("timeout: the tests did not finish within %0d cycles", timeout_cycles);
        abort_run();
    end
end

initial begin : tests
    logic [63:0] t0;
    logic [63:0] t1;
    logic [63:0] cmp;
    logic [31:0] rnd;
    int unsigned acc0;
    int unsigned acc1;
    int unsigned nearest;
    int unsigned delta;
    req_valid <= 1'b0;
    req_write <= 1'b0;
    req_addr  <= '0;
    req_wdata <= '0;
    rsp_ready <= 1'b0;
    model_en    = '0;
    model_pend  = '0;
    model_fired = '0;
    @(posedge rstn_sys);
    repeat (4) @(posedge clk_sys);

    check("irq after reset", 0, irq);
    check("rsp_valid after reset", 0, rsp_valid);
    check("req_ready after reset", 1, req_ready);
    check_reg("status after reset", systimer_pkg::addr_status, '0);
    check_reg("ctrl after reset", systimer_pkg::addr_ctrl, '0);
    read_time(t0, acc0);
    check("time before first slow edge", 0, t0);

    // the slow domain leaves reset a few slow edges later and the measurement starts after that
    repeat (100) @(posedge clk_sys);
    read_time(t0, acc0);
    for (int i = 0; i < 6; i++) begin
        draw_bits(7, rnd);
        repeat (120 + rnd) @(posedge clk_sys);
        read_time(t1, acc1);
        check("time not decreasing", 1, t1 >= t0);
        nearest = (acc1 - acc0 + counts_div / 2) / counts_div;
        delta   = t1 - t0;
        if (delta * counts_div + counts_div >= acc1 - acc0 &&
            delta * counts_div <= acc1 - acc0 + counts_div) begin
            delta = nearest;  // within one count of the ideal rate
        end
        check("time rate", nearest, delta);
        t0   = t1;
        acc0 = acc1;
    end

    for (int n = 0; n < systimer_pkg::num_cmp; n++) begin
        draw_bits(32, rnd);
        reg_write(chan_addr(n, 1'b0), rnd);
        draw_bits(32, rnd);
        reg_write(chan_addr(n, 1'b1), rnd);
    end
    for (int n = 0; n < systimer_pkg::num_cmp; n++) begin
        check_reg("compare low readback", chan_addr(n, 1'b0), t0);
        check_reg("compare high readback", chan_addr(n, 1'b1), t0);
    end
    draw_bits(32, rnd);
    reg_write(4'd12, rnd);
    check_reg("undefined address 12", 4'd12, t0);
    draw_bits(32, rnd);
    reg_write(4'd15, rnd);
    check_reg("undefined address 15", 4'd15, t0);

    read_time(t0, acc0);
    reg_write(chan_addr(1, 1'b0), t0[31:0]);  // channel 1 is already passed but stays off
    reg_write(chan_addr(1, 1'b1), t0[63:32]);
    repeat (40) @(posedge clk_sys);
    check("irq with channels off", 0, irq);
    check_reg("status with channels off", systimer_pkg::addr_status, t0);
    draw_bits(6, rnd);
    cmp = t0 + 4 + rnd;
    reg_write(chan_addr(0, 1'b0), cmp[31:0]);
    reg_write(chan_addr(0, 1'b1), cmp[63:32]);
    reg_write(systimer_pkg::addr_ctrl, 32'h1);
    check_reg("ctrl readback", systimer_pkg::addr_ctrl, t0);
    wait_irq();
    read_time(t1, acc1);
    check("time at irq reached compare", 1, t1 >= cmp);
    check_reg("status after channel 0 hit", systimer_pkg::addr_status, t1);
    check("irq with channel 0 pending", |(model_pend & model_en), irq);

    draw_bits(6, rnd);
    cmp = t1 + 4 + rnd;
    reg_write(chan_addr(1, 1'b0), cmp[31:0]);
    reg_write(chan_addr(1, 1'b1), cmp[63:32]);
    reg_write(systimer_pkg::addr_ctrl, 32'h3);
    do begin
        read_time(t1, acc1);
    end while (t1 < cmp);
    check_reg("status after channel 1 hit", systimer_pkg::addr_status, t1);

    reg_write(systimer_pkg::addr_status, 32'h1);
    check_reg("status after clearing channel 0", systimer_pkg::addr_status, t1);
    @(posedge clk_sys);
    check("irq with channel 1 pending", |(model_pend & model_en), irq);
    reg_write(systimer_pkg::addr_status, 32'h2);
    @(posedge clk_sys);
    check("irq after clearing all", |(model_pend & model_en), irq);
    check_reg("status after clearing all", systimer_pkg::addr_status, t1);

    $display("All tests passed");
    $finish;
end

endmodule

//--- hw/resetn_synchronizer.sv
`timescale 1ns/10ps

module resetn_synchronizer (
    input  logic clk,
    input  logic rstn_async,
    output logic rstn_sync
);

// the reset asserts at once and releases two clk edges after the external release
logic [1:0] sync_q;

always_ff @(posedge clk or negedge rstn_async) begin
    if (!rstn_async) begin
        sync_q <= 2'b00;
    end else begin
        sync_q <= {sync_q[0], 1'b1};  // ones shift in after release
    end
end

assign rstn_sync = sync_q[1];

endmodule

//--- hw/systimer.sv
`timescale 1ns/10ps

module systimer (
    input  logic                               clk_sys,
    input  logic                               clk_32k,
    input  logic                               rstn_32k,
    input  logic                               rstn_sys,
    output logic [systimer_pkg::time_width-1:0] systime
);

// gray code lets the count cross into clk_sys with only one bit moving per step
function automatic logic [systimer_pkg::time_width-1:0] bin2gray(
    input logic [systimer_pkg::time_width-1:0] bin
);
    return bin ^ (bin >> 1);
endfunction

function automatic logic [systimer_pkg::time_width-1:0] gray2bin(
    input logic [systimer_pkg::time_width-1:0] gray
);
    logic [systimer_pkg::time_width-1:0] bin;
    bin[systimer_pkg::time_width-1] = gray[systimer_pkg::time_width-1];
    for (int i = systimer_pkg::time_width - 2; i >= 0; i--) begin
        bin[i] = bin[i+1] ^ gray[i];
    end
    return bin;
endfunction

logic [systimer_pkg::time_width-1:0] timer_gray;
logic [systimer_pkg::time_width-1:0] timer_bin;
logic [systimer_pkg::time_width-1:0] gray_d1;
logic [systimer_pkg::time_width-1:0] gray_d2;

assign timer_bin = gray2bin(timer_gray);

// free-running count in the slow domain
always_ff @(posedge clk_32k or negedge rstn_32k) begin
    if (!rstn_32k) begin
        timer_gray <= '0;
    end else begin
        timer_gray <= bin2gray(timer_bin + 1'b1);
    end
end

// two-flop synchronizer into clk_sys
always_ff @(posedge clk_sys or negedge rstn_sys) begin
    if (!rstn_sys) begin
        gray_d1 <= '0;
        gray_d2 <= '0;
    end else begin
        gray_d1 <= timer_gray;
        gray_d2 <= gray_d1;
    end
end

// third edge after the slow clock, the binary time is registered for the consumers
always_ff @(posedge clk_sys or negedge rstn_sys) begin
    if (!rstn_sys) begin
        systime <= '0;
    end else begin
        systime <= gray2bin(gray_d2);
    end
end

// a wider jump here means the slow clock outran the synchronizer
assert property (@(posedge clk_sys) disable iff (!rstn_sys)
    $countones(gray_d2 ^ $past(gray_d2)) <= 1);

assert property (@(posedge clk_sys) disable iff (!rstn_sys)
    systime >= $past(systime));

endmodule

//--- hw/systimer_pkg.sv
package systimer_pkg;

// datapath widths
localparam int unsigned time_width = 64;
localparam int unsigned data_width = 32;
localparam int unsigned addr_width = 4;

// number of compare channels, the address map leaves room for up to 3 without overlap
localparam int unsigned num_cmp = 2;

// word addresses of the register file
localparam logic [addr_width-1:0] addr_time_lo = 4'd0;  // read latches the high word
localparam logic [addr_width-1:0] addr_time_hi = 4'd1;  // returns the latched high word
localparam logic [addr_width-1:0] addr_cmp0_lo = 4'd2;
localparam logic [addr_width-1:0] addr_cmp0_hi = 4'd3;
localparam logic [addr_width-1:0] addr_ctrl    = 4'd8;  // interrupt enables
localparam logic [addr_width-1:0] addr_status  = 4'd9;  // pending bits, write one to clear

// address of one word of a compare channel, each channel takes two words
function automatic logic [addr_width-1:0] cmp_addr(
    input int unsigned ch,
    input logic        hi
);
    logic [addr_width-1:0] base;
    base = hi ? addr_cmp0_hi : addr_cmp0_lo;
    return base + addr_width'(2 * ch);
endfunction

endpackage

//--- hw/timer_compare.sv
`timescale 1ns/10ps

module timer_compare (
    input  logic                               clk_sys,
    input  logic                               rstn_sys,
    input  logic [systimer_pkg::time_width-1:0] systime,
    input  logic [systimer_pkg::time_width-1:0] cmp_value,
    input  logic                               cmp_enable,
    input  logic                               cmp_clear,
    output logic                               pending
);

logic reached;
logic enable_q;
logic armed;
logic fire;

assign reached = systime >= cmp_value;

// armed while enabled and the time is still below the compare value,
// and once right after enable rises so an already passed value still fires
assign fire = cmp_enable & armed & reached;

always_ff @(posedge clk_sys or negedge rstn_sys) begin
    if (!rstn_sys) begin
        enable_q <= 1'b0;
        armed    <= 1'b0;
    end else begin
        enable_q <= cmp_enable;
        if (!cmp_enable) begin
            armed <= 1'b0;  // disarm whenever the channel is off
        end else if (!reached || !enable_q) begin
            armed <= 1'b1;
        end else begin
            armed <= 1'b0;  // a hit consumes the arm, so a clear does not retrigger
        end
    end
end

always_ff @(posedge clk_sys or negedge rstn_sys) begin
    if (!rstn_sys) begin
        pending <= 1'b0;
    end else if (cmp_clear) begin
        pending <= 1'b0;  // software clear has priority over a new hit
    end else if (fire) begin
        pending <= 1'b1;
    end
end

// a crossing seen while the channel stays enabled sets pending on the next edge
assert property (@(posedge clk_sys) disable iff (!rstn_sys)
    cmp_enable && enable_q && reached && !$past(reached) && !cmp_clear |=> pending);

endmodule

//--- hw/timer_regs.sv
`timescale 1ns/10ps

module timer_regs (
    input  logic                               clk_sys,
    input  logic                               rstn_sys,

    input  logic                               req_valid,
    output logic                               req_ready,
    input  logic                               req_write,
    input  logic [systimer_pkg::addr_width-1:0] req_addr,
    input  logic [systimer_pkg::data_width-1:0] req_wdata,

    output logic                               rsp_valid,
    input  logic                               rsp_ready,
    output logic [systimer_pkg::data_width-1:0] rsp_rdata,

    input  logic [systimer_pkg::time_width-1:0] systime,
    input  logic [systimer_pkg::num_cmp-1:0]    pending,

    output logic [systimer_pkg::time_width-1:0] cmp_value [systimer_pkg::num_cmp],
    output logic [systimer_pkg::num_cmp-1:0]    cmp_enable,
    output logic [systimer_pkg::num_cmp-1:0]    cmp_clear,

    output logic                               irq
);

logic                                accept;
logic                                wr_acc;
logic                                rd_acc;
logic [systimer_pkg::data_width-1:0] rd_data;
logic [systimer_pkg::data_width-1:0] snap_hi;
logic [systimer_pkg::time_width-1:0] cmp_q [systimer_pkg::num_cmp];

// only one access is in flight and a new request waits until the response is taken
assign req_ready = ~rsp_valid;
assign accept    = req_valid & req_ready;
assign wr_acc    = accept & req_write;
assign rd_acc    = accept & ~req_write;

// undefined addresses read as zero
always_comb begin
    rd_data = '0;
    case (req_addr)
        systimer_pkg::addr_time_lo: rd_data = systime[systimer_pkg::data_width-1:0];
        systimer_pkg::addr_time_hi: rd_data = snap_hi;
        systimer_pkg::addr_ctrl:    rd_data[systimer_pkg::num_cmp-1:0] = cmp_enable;
        systimer_pkg::addr_status:  rd_data[systimer_pkg::num_cmp-1:0] = pending;
        default: begin
            for (int n = 0; n < systimer_pkg::num_cmp; n++) begin
                if (req_addr == systimer_pkg::cmp_addr(n, 1'b0)) begin
                    rd_data = cmp_q[n][systimer_pkg::data_width-1:0];
                end
                if (req_addr == systimer_pkg::cmp_addr(n, 1'b1)) begin
                    rd_data = cmp_q[n][systimer_pkg::time_width-1:systimer_pkg::data_width];
                end
            end
        end
    endcase
end

// response handshake
always_ff @(posedge clk_sys or negedge rstn_sys) begin
    if (!rstn_sys) begin
        rsp_valid <= 1'b0;
    end else if (accept) begin
        rsp_valid <= 1'b1;
    end else if (rsp_ready) begin
        rsp_valid <= 1'b0;
    end
end

always_ff @(posedge clk_sys) begin
    if (accept) begin
        rsp_rdata <= req_write ? '0 : rd_data;  // writes answer with zero
    end
end

// the high word is taken from the same sample as the low word just returned
always_ff @(posedge clk_sys) begin
    if (rd_acc && req_addr == systimer_pkg::addr_time_lo) begin
        snap_hi <= systime[systimer_pkg::time_width-1:systimer_pkg::data_width];
    end
end

always_ff @(posedge clk_sys) begin
    if (wr_acc) begin
        for (int n = 0; n < systimer_pkg::num_cmp; n++) begin
            if (req_addr == systimer_pkg::cmp_addr(n, 1'b0)) begin
                cmp_q[n][systimer_pkg::data_width-1:0] <= req_wdata;
            end
            if (req_addr == systimer_pkg::cmp_addr(n, 1'b1)) begin
                cmp_q[n][systimer_pkg::time_width-1:systimer_pkg::data_width] <= req_wdata;
            end
        end
    end
end

assign cmp_value = cmp_q;

always_ff @(posedge clk_sys or negedge rstn_sys) begin
    if (!rstn_sys) begin
        cmp_enable <= '0;
    end else if (wr_acc && req_addr == systimer_pkg::addr_ctrl) begin
        cmp_enable <= req_wdata[systimer_pkg::num_cmp-1:0];
    end
end

// the clear pulse lasts only the acceptance cycle, so pending drops on that edge
always_comb begin
    cmp_clear = '0;
    if (wr_acc && req_addr == systimer_pkg::addr_status) begin
        cmp_clear = req_wdata[systimer_pkg::num_cmp-1:0];
    end
end

always_ff @(posedge clk_sys or negedge rstn_sys) begin
    if (!rstn_sys) begin
        irq <= 1'b0;
    end else begin
        irq <= |(pending & cmp_enable);
    end
end

// a stalled response must not change under the consumer
assert property (@(posedge clk_sys) disable iff (!rstn_sys)
    rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp_rdata));

endmodule

//--- hw/timer_subsys_top.sv
`timescale 1ns/10ps

module timer_subsys_top (
    input  logic                               clk_sys,
    input  logic                               clk_32k,
    input  logic                               rstn_sys,  // external, asynchronous

    input  logic                               req_valid,
    output logic                               req_ready,
    input  logic                               req_write,
    input  logic [systimer_pkg::addr_width-1:0] req_addr,
    input  logic [systimer_pkg::data_width-1:0] req_wdata,

    output logic                               rsp_valid,
    input  logic                               rsp_ready,
    output logic [systimer_pkg::data_width-1:0] rsp_rdata,

    output logic                               irq
);

logic                                rstn_sys_sync;
logic                                rstn_32k;
logic [systimer_pkg::time_width-1:0] systime;
logic [systimer_pkg::time_width-1:0] cmp_value [systimer_pkg::num_cmp];
logic [systimer_pkg::num_cmp-1:0]    cmp_enable;
logic [systimer_pkg::num_cmp-1:0]    cmp_clear;
logic [systimer_pkg::num_cmp-1:0]    pending;

resetn_synchronizer u_rst_sync_sys (
    .clk        ( clk_sys       ),
    .rstn_async ( rstn_sys      ),
    .rstn_sync  ( rstn_sys_sync )
);

resetn_synchronizer u_rst_sync_32k (
    .clk        ( clk_32k  ),
    .rstn_async ( rstn_sys ),
    .rstn_sync  ( rstn_32k )
);

systimer u_systimer (
    .clk_sys  ( clk_sys       ),
    .clk_32k  ( clk_32k       ),
    .rstn_32k ( rstn_32k      ),
    .rstn_sys ( rstn_sys_sync ),
    .systime  ( systime       )
);

timer_regs u_regs (
    .clk_sys    ( clk_sys       ),
    .rstn_sys   ( rstn_sys_sync ),
    .req_valid  ( req_valid     ),
    .req_ready  ( req_ready     ),
    .req_write  ( req_write     ),
    .req_addr   ( req_addr      ),
    .req_wdata  ( req_wdata     ),
    .rsp_valid  ( rsp_valid     ),
    .rsp_ready  ( rsp_ready     ),
    .rsp_rdata  ( rsp_rdata     ),
    .systime    ( systime       ),
    .pending    ( pending       ),
    .cmp_value  ( cmp_value     ),
    .cmp_enable ( cmp_enable    ),
    .cmp_clear  ( cmp_clear     ),
    .irq        ( irq           )
);

for (genvar i = 0; i < systimer_pkg::num_cmp; i++) begin : g_cmp
    timer_compare u_cmp (
        .clk_sys    ( clk_sys       ),
        .rstn_sys   ( rstn_sys_sync ),
        .systime    ( systime       ),
        .cmp_value  ( cmp_value[i]  ),
        .cmp_enable ( cmp_enable[i] ),
        .cmp_clear  ( cmp_clear[i]  ),
        .pending    ( pending[i]    )
    );
end

endmodule

//--- vlog.f
hw/systimer_pkg.sv
hw/resetn_synchronizer.sv
hw/systimer.sv
hw/timer_compare.sv
hw/timer_regs.sv
hw/timer_subsys_top.sv
dv/tb_clkgen.sv
dv/tb_timer_subsys.sv
